//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = exec_core_tb
FILELIST  = tb.f
PASS_MSG  = Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- bench/clock_gen.sv
`default_nettype none
`timescale 1ns/10ps

module clock_gen (
    output logic clock,
    output logic reset
);
    // half of the 20 ns period
    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 8;

    initial begin
        clock = 1'b0;
        forever #(HALF_PERIOD) clock = ~clock;
    end

    // reset drops on a rising edge
    initial begin
        reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

//--- bench/exec_core_tb.sv
`default_nettype none
`timescale 1ns/10ps

`include "exec_defs.svh"

module exec_core_tb;
    import exec_pkg::*;

    // trace layout and run limits
    localparam int N_OPS          = 16;
    localparam int N_COLS         = 6;
    localparam int N_TAGS         = 1 << `TAG_W;
    localparam int XW             = `XLEN;
    localparam int TIMEOUT_CYCLES = N_OPS * 40 + 100;
    // quiet cycles after the last result to catch repeats
    localparam int DRAIN_CYCLES   = 30;

    logic              clock;
    logic              reset;
    logic              dispatch_req;
    logic              fu_sel;
    op_ctrl_u          op_ctrl;
    logic [XW-1:0]     operand_a;
    logic [XW-1:0]     operand_b;
    logic [`TAG_W-1:0] op_tag;
    logic              dispatch_ack;
    logic              cdb_valid;
    logic [`TAG_W-1:0] cdb_tag;
    logic [XW-1:0]     cdb_value;

    // six words per operation
    logic [31:0]   trace_mem  [0:N_OPS*N_COLS-1];
    logic [XW-1:0] exp_value  [0:N_TAGS-1];
    bit            in_trace   [0:N_TAGS-1];
    bit            dispatched [0:N_TAGS-1];
    int            seen_count [0:N_TAGS-1];
    int            seen_cycle [0:N_TAGS-1];
    int            ack_cycle  [0:N_OPS-1];

    int         cycle;
    int         results_seen;
    int         value_errors;
    int         bus_errors;
    int         sequence_errors;
    bit         reset_checked;
    logic [7:0] lfsr_state;

    clock_gen u_clock_gen (
        .clock (clock),
        .reset (reset)
    );

    exec_core u_exec_core (
        .clock        (clock),
        .reset        (reset),
        .dispatch_req (dispatch_req),
        .fu_sel       (fu_sel),
        .op_ctrl      (op_ctrl),
        .operand_a    (operand_a),
        .operand_b    (operand_b),
        .op_tag       (op_tag),
        .dispatch_ack (dispatch_ack),
        .cdb_valid    (cdb_valid),
        .cdb_tag      (cdb_tag),
        .cdb_value    (cdb_value)
    );

    //////////////////////////////
    // helpers
    //////////////////////////////
    // 8-bit fibonacci lfsr with taps 8 6 5 4
    function automatic logic [7:0] next_lfsr(input logic [7:0] state);
        logic feedback;
        feedback = state[7] ^ state[5] ^ state[4] ^ state[3];
        return {state[6:0], feedback};
    endfunction

    // two fresh bits give a gap of 0 to 3
    task automatic draw_gap(output int gap);
        logic [1:0] bits;
        lfsr_state = next_lfsr(lfsr_state);
        bits[0]    = lfsr_state[0];
        lfsr_state = next_lfsr(lfsr_state);
        bits[1]    = lfsr_state[0];
        gap        = int'(bits);
    endtask

    task automatic compare_value(input string name, input logic [XW-1:0] got,
                                 input logic [XW-1:0] expected);
        if (got !== expected) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, expected);
            value_errors++;
        end
    endtask

    // one four-phase transfer
    task automatic send_op(input int idx);
        int base;
        base = idx * N_COLS;
        dispatch_req <= 1'b1;
        fu_sel       <= trace_mem[base][0];
        op_ctrl      <= trace_mem[base + 1][7:0];
        operand_a    <= trace_mem[base + 2];
        operand_b    <= trace_mem[base + 3];
        op_tag       <= trace_mem[base + 4][`TAG_W-1:0];
        // hold req until ack shows up
        do begin
            @(posedge clock);
        end while (!dispatch_ack);
        ack_cycle[idx] = cycle;
        dispatched[trace_mem[base + 4][`TAG_W-1:0]] = 1'b1;
        dispatch_req <= 1'b0;
        do begin
            @(posedge clock);
        end while (dispatch_ack);
    endtask

    task automatic finish_run(input bit timed_out);
        $display("errors: value %0d, bus %0d, sequence %0d",
                 value_errors, bus_errors, sequence_errors);
        if (!timed_out && value_errors == 0 && bus_errors == 0 && sequence_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    //////////////////////////////
    // cycle count and timeout
    //////////////////////////////
    always @(posedge clock) begin
        if (reset) begin
            cycle <= 0;
        end else begin
            cycle <= cycle + 1;
            if (cycle >= TIMEOUT_CYCLES) begin
                $display("timeout: the run did not complete within %0d cycles",
                         TIMEOUT_CYCLES);
                finish_run(1'b1);
            end
        end
    end

    //////////////////////////////
    // result bus monitor
    //////////////////////////////
    always @(posedge clock) begin
        if (!reset) begin
            // first edge out of reset
            if (!reset_checked) begin
                compare_value("dispatch_ack", XW'(dispatch_ack), '0);
                compare_value("cdb_valid", XW'(cdb_valid), '0);
                reset_checked <= 1'b1;
            end
            if (cdb_valid) begin
                if (!in_trace[cdb_tag] || !dispatched[cdb_tag]) begin
                    $display("error at %0t: result bus carried tag %0h, which was not dispatched",
                             $time, cdb_tag);
                    bus_errors++;
                end else if (seen_count[cdb_tag] != 0) begin
                    $display("error at %0t: tag %0h appeared on the result bus more than once",
                             $time, cdb_tag);
                    bus_errors++;
                end else begin
                    compare_value("cdb_value", cdb_value, exp_value[cdb_tag]);
                    results_seen        <= results_seen + 1;
                    seen_cycle[cdb_tag] <= cycle;
                end
                seen_count[cdb_tag] <= seen_count[cdb_tag] + 1;
            end
        end
    end

    //////////////////////////////
    // stimulus and final checks
    //////////////////////////////
    initial begin
        int gap;
        int base;
        int tag;
        int prev_tag;
        int prev_mult;
        dispatch_req <= 1'b0;
        fu_sel       <= 1'b0;
        op_ctrl      <= '0;
        operand_a    <= '0;
        operand_b    <= '0;
        op_tag       <= '0;
        lfsr_state = 8'd70;
        $readmemh("bench/exec_trace.txt", trace_mem);
        // expected value table by tag
        for (int i = 0; i < N_OPS; i++) begin
            base           = i * N_COLS;
            tag            = int'(trace_mem[base + 4][`TAG_W-1:0]);
            in_trace[tag]  = 1'b1;
            exp_value[tag] = trace_mem[base + 5];
        end
        do begin
            @(posedge clock);
        end while (reset);
        for (int i = 0; i < N_OPS; i++) begin
            draw_gap(gap);
            repeat (gap) @(posedge clock);
            send_op(i);
        end
        while (results_seen < N_OPS) begin
            @(posedge clock);
        end
        repeat (DRAIN_CYCLES) @(posedge clock);
        for (int t = 0; t < N_TAGS; t++) begin
            if (in_trace[t] && seen_count[t] == 0) begin
                $display("error: tag %0h never appeared on the result bus", t);
                sequence_errors++;
            end
        end
        // a multiply waits for the previous product to leave the bus
        prev_mult = -1;
        for (int i = 0; i < N_OPS; i++) begin
            base = i * N_COLS;
            if (trace_mem[base][0]) begin
                if (prev_mult >= 0) begin
                    prev_tag = int'(trace_mem[prev_mult * N_COLS + 4][`TAG_W-1:0]);
                    if (seen_cycle[prev_tag] >= ack_cycle[i]) begin
                        $display("error: multiply %0d was acknowledged before the previous %s",
                                 i, "multiply result left the bus");
                        sequence_errors++;
                    end
                end
                prev_mult = i;
            end
        end
        finish_run(1'b0);
    end

endmodule

`default_nettype wire

//--- bench/exec_trace.txt
// fu_sel op_ctrl operand_a operand_b op_tag expected
// fu_sel 1 is the multiplier, its op_ctrl bits 2..0 are high signed_a signed_b
0 00 12345678 11111111 0 23456789 // add
0 01 00000005 00000007 1 fffffffe // sub
1 00 00012345 00000100 9 01234500 // mul low unsigned
0 02 f0f0f0f0 0ff00ff0 2 00f000f0 // and
0 03 a5000000 0000005a 3 a500005a // or
1 04 ffffffff ffffffff a fffffffe // mul high unsigned
1 07 ffffffff ffffffff b 00000000 // mul high signed
0 04 ffff0000 0f0f0f0f 4 f0f00f0f // xor
0 05 00000003 ffffffe4 5 00000030 // sll by low 5 bits
1 03 fffffffd 00000007 c ffffffeb // mul low signed
0 06 80000000 0000003f 6 00000001 // srl by 31
1 06 fffffffe 80000000 d ffffffff // mul high signed a unsigned b
0 07 ffffffff 00000001 7 00000001 // slt signed
1 07 80000000 80000000 e 40000000 // mul high most negative squared
1 01 00000010 ffffffff f fffffff0 // mul low unsigned a signed b
0 08 ffffffff 00000001 8 00000000 // sltu unsigned

//--- design/alu_unit.sv
`default_nettype none
`timescale 1ns/10ps

`include "exec_defs.svh"

module alu_unit (
    input  wire                   clock,
    input  wire                   reset,
    input  wire                   alu_start,
    input  wire exec_pkg::op_ctrl_u op_ctrl,
    input  wire [`XLEN-1:0]       operand_a,
    input  wire [`XLEN-1:0]       operand_b,
    input  wire [`TAG_W-1:0]      op_tag,
    input  wire                   grant,
    output logic                  busy,
    output logic                  done,
    output logic [`XLEN-1:0]      result,
    output logic [`TAG_W-1:0]     result_tag
);
    import exec_pkg::*;

    logic [`XLEN-1:0] alu_out;
    logic [4:0]       shamt;

    // shifts take the low five bits of b
    assign shamt = operand_b[4:0];

    //////////////////////////////
    // single cycle datapath
    //////////////////////////////
    always_comb begin
        case (op_ctrl.alu.func)
            ALU_ADD:  alu_out = operand_a + operand_b;
            ALU_SUB:  alu_out = operand_a - operand_b;
            ALU_AND:  alu_out = operand_a & operand_b;
            ALU_OR:   alu_out = operand_a | operand_b;
            ALU_XOR:  alu_out = operand_a ^ operand_b;
            ALU_SLL:  alu_out = operand_a << shamt;
            ALU_SRL:  alu_out = operand_a >> shamt;
            // signed set on less than
            ALU_SLT:  alu_out = {{(`XLEN-1){1'b0}}, $signed(operand_a) < $signed(operand_b)};
            // unsigned set on less than
            ALU_SLTU: alu_out = {{(`XLEN-1){1'b0}}, operand_a < operand_b};
            default:  alu_out = '0;
        endcase
    end

    // done holds until the arbiter takes the result
    always_ff @(posedge clock) begin
        if (reset) begin
            done <= 1'b0;
        end else if (alu_start) begin
            done <= 1'b1;
        end else if (grant) begin
            done <= 1'b0;
        end
    end

    // holding registers for value and tag
    always_ff @(posedge clock) begin
        if (alu_start) begin
            result     <= alu_out;
            result_tag <= op_tag;
        end
    end

    // compute finishes at the start edge
    // so only a held result keeps the unit busy
    assign busy = done;

    // dispatch must wait out the held result
    a_no_start_when_done: assert property (@(posedge clock) disable iff (reset)
        alu_start |-> !done);

endmodule

`default_nettype wire

//--- design/cdb_arbiter.sv
`default_nettype none
`timescale 1ns/10ps

`include "exec_defs.svh"

module cdb_arbiter (
    input  wire               clock,
    input  wire               reset,
    input  wire               alu_done,
    input  wire [`XLEN-1:0]   alu_result,
    input  wire [`TAG_W-1:0]  alu_tag,
    input  wire               mult_done,
    input  wire [`XLEN-1:0]   mult_result,
    input  wire [`TAG_W-1:0]  mult_tag,
    output logic              alu_grant,
    output logic              mult_grant,
    output logic              cdb_valid,
    output logic [`TAG_W-1:0] cdb_tag,
    output logic [`XLEN-1:0]  cdb_value
);

    //////////////////////////////
    // fixed priority select
    //////////////////////////////
    // multiplier wins and the alu waits a cycle
    assign mult_grant = mult_done;
    assign alu_grant  = alu_done && !mult_done;

    // one result per cycle on the bus
    always_ff @(posedge clock) begin
        if (reset) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= alu_grant || mult_grant;
        end
    end

    // bus payload
    always_ff @(posedge clock) begin
        if (mult_grant) begin
            cdb_tag   <= mult_tag;
            cdb_value <= mult_result;
        end else if (alu_grant) begin
            cdb_tag   <= alu_tag;
            cdb_value <= alu_result;
        end
    end

    a_grant_onehot: assert property (@(posedge clock) disable iff (reset)
        !(alu_grant && mult_grant));

endmodule

`default_nettype wire

//--- design/dispatch_port.sv
`default_nettype none
`timescale 1ns/10ps

`include "exec_defs.svh"

module dispatch_port (
    input  wire                   clock,
    input  wire                   reset,
    input  wire                   dispatch_req,
    input  wire                   fu_sel,
    input  wire exec_pkg::op_ctrl_u op_ctrl,
    input  wire [`XLEN-1:0]       operand_a,
    input  wire [`XLEN-1:0]       operand_b,
    input  wire [`TAG_W-1:0]      op_tag,
    input  wire                   alu_busy,
    input  wire                   mult_busy,
    output logic                  dispatch_ack,
    output logic                  alu_start,
    output logic                  mult_start,
    output exec_pkg::op_ctrl_u    op_ctrl_q,
    output logic [`XLEN-1:0]      operand_a_q,
    output logic [`XLEN-1:0]      operand_b_q,
    output logic [`TAG_W-1:0]     op_tag_q
);
    import exec_pkg::*;

    // handshake states
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_ACK  = 2'd1;
    localparam logic [1:0] ST_WAIT = 2'd2;

    logic [1:0] state;
    logic       sel_busy;
    logic       accept;

    // busy of the unit the source asks for
    assign sel_busy = fu_sel ? mult_busy : alu_busy;
    assign accept   = (state == ST_IDLE) && dispatch_req && !sel_busy;

    //////////////////////////////
    // four-phase req/ack FSM
    //////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            state        <= ST_IDLE;
            dispatch_ack <= 1'b0;
            alu_start    <= 1'b0;
            mult_start   <= 1'b0;
        end else begin
            // start is a single cycle pulse
            alu_start  <= 1'b0;
            mult_start <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state        <= ST_ACK;
                        dispatch_ack <= 1'b1;
                        alu_start    <= !fu_sel;
                        mult_start   <= fu_sel;
                    end
                end
                ST_ACK: begin
                    // source has not seen ack yet
                    state <= dispatch_req ? ST_WAIT : ST_IDLE;
                    if (!dispatch_req) begin
                        dispatch_ack <= 1'b0;
                    end
                end
                ST_WAIT: begin
                    // drop ack once req is released
                    if (!dispatch_req) begin
                        state        <= ST_IDLE;
                        dispatch_ack <= 1'b0;
                    end
                end
                default: begin
                    state        <= ST_IDLE;
                    dispatch_ack <= 1'b0;
                end
            endcase
        end
    end

    // operation fields held for the unit
    always_ff @(posedge clock) begin
        if (accept) begin
            op_ctrl_q   <= op_ctrl;
            operand_a_q <= operand_a;
            operand_b_q <= operand_b;
            op_tag_q    <= op_tag;
        end
    end

    // unit must still be free when its start lands
    a_start_free: assert property (@(posedge clock) disable iff (reset)
        (alu_start |-> !alu_busy) and (mult_start |-> !mult_busy));

    // ack only answers a live request
    a_ack_on_req: assert property (@(posedge clock) disable iff (reset)
        $rose(dispatch_ack) |-> $past(dispatch_req));

endmodule

`default_nettype wire

//--- design/exec_core.sv
`default_nettype none
`timescale 1ns/10ps

`include "exec_defs.svh"

module exec_core (
    input  wire                   clock,
    input  wire                   reset,
    input  wire                   dispatch_req,
    input  wire                   fu_sel,
    input  wire exec_pkg::op_ctrl_u op_ctrl,
    input  wire [`XLEN-1:0]       operand_a,
    input  wire [`XLEN-1:0]       operand_b,
    input  wire [`TAG_W-1:0]      op_tag,
    output logic                  dispatch_ack,
    output logic                  cdb_valid,
    output logic [`TAG_W-1:0]     cdb_tag,
    output logic [`XLEN-1:0]      cdb_value
);
    import exec_pkg::*;

    // dispatch to units
    logic             alu_start;
    logic             mult_start;
    op_ctrl_u         op_ctrl_q;
    logic [`XLEN-1:0] operand_a_q;
    logic [`XLEN-1:0] operand_b_q;
    logic [`TAG_W-1:0] op_tag_q;

    // units back to dispatch and arbiter
    logic              alu_busy;
    logic              alu_done;
    logic [`XLEN-1:0]  alu_result;
    logic [`TAG_W-1:0] alu_tag;
    logic              alu_grant;
    logic              mult_busy;
    logic              mult_done;
    logic [`XLEN-1:0]  mult_result;
    logic [`TAG_W-1:0] mult_tag;
    logic              mult_grant;

    //////////////////////////////
    // dispatch
    //////////////////////////////
    dispatch_port u_dispatch_port (
        .clock        (clock),
        .reset        (reset),
        .dispatch_req (dispatch_req),
        .fu_sel       (fu_sel),
        .op_ctrl      (op_ctrl),
        .operand_a    (operand_a),
        .operand_b    (operand_b),
        .op_tag       (op_tag),
        .alu_busy     (alu_busy),
        .mult_busy    (mult_busy),
        .dispatch_ack (dispatch_ack),
        .alu_start    (alu_start),
        .mult_start   (mult_start),
        .op_ctrl_q    (op_ctrl_q),
        .operand_a_q  (operand_a_q),
        .operand_b_q  (operand_b_q),
        .op_tag_q     (op_tag_q)
    );

    //////////////////////////////
    // execution units
    //////////////////////////////
    // both units share the captured fields
    alu_unit u_alu_unit (
        .clock      (clock),
        .reset      (reset),
        .alu_start  (alu_start),
        .op_ctrl    (op_ctrl_q),
        .operand_a  (operand_a_q),
        .operand_b  (operand_b_q),
        .op_tag     (op_tag_q),
        .grant      (alu_grant),
        .busy       (alu_busy),
        .done       (alu_done),
        .result     (alu_result),
        .result_tag (alu_tag)
    );

    mult_unit u_mult_unit (
        .clock      (clock),
        .reset      (reset),
        .mult_start (mult_start),
        .op_ctrl    (op_ctrl_q),
        .operand_a  (operand_a_q),
        .operand_b  (operand_b_q),
        .op_tag     (op_tag_q),
        .grant      (mult_grant),
        .busy       (mult_busy),
        .done       (mult_done),
        .result     (mult_result),
        .result_tag (mult_tag)
    );

    // result bus
    cdb_arbiter u_cdb_arbiter (
        .clock       (clock),
        .reset       (reset),
        .alu_done    (alu_done),
        .alu_result  (alu_result),
        .alu_tag     (alu_tag),
        .mult_done   (mult_done),
        .mult_result (mult_result),
        .mult_tag    (mult_tag),
        .alu_grant   (alu_grant),
        .mult_grant  (mult_grant),
        .cdb_valid   (cdb_valid),
        .cdb_tag     (cdb_tag),
        .cdb_value   (cdb_value)
    );

endmodule

`default_nettype wire

//--- design/exec_defs.svh
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

// operand and result width
`define XLEN 32

// tag carried by each operation to the bus
`define TAG_W 4

// operation control word width
`define CTRL_W 8

// multiplier iterations at two bits per step
`define MULT_STEPS 16

`endif

//--- design/exec_pkg.sv
`default_nettype none

`include "exec_defs.svh"

package exec_pkg;

    // integer unit function codes
    typedef enum logic [3:0] {
        ALU_ADD  = 4'h0,
        ALU_SUB  = 4'h1,
        ALU_AND  = 4'h2,
        ALU_OR   = 4'h3,
        ALU_XOR  = 4'h4,
        ALU_SLL  = 4'h5,
        ALU_SRL  = 4'h6,
        ALU_SLT  = 4'h7,
        ALU_SLTU = 4'h8
    } alu_func_e;

    // one control word seen two ways
    // the integer unit reads the alu view
    // the multiplier reads the mult view
    typedef union packed {
        struct packed {
            logic [`CTRL_W-5:0] unused;
            alu_func_e          func;
        } alu;
        struct packed {
            logic [`CTRL_W-4:0] unused;
            // upper half of the 64-bit product
            logic               high;
            // operand a taken as signed
            logic               signed_a;
            // operand b taken as signed
            logic               signed_b;
        } mult;
    } op_ctrl_u;

endpackage

`default_nettype wire

//--- design/mult_unit.sv
`default_nettype none
`timescale 1ns/10ps

`include "exec_defs.svh"

module mult_unit (
    input  wire                   clock,
    input  wire                   reset,
    input  wire                   mult_start,
    input  wire exec_pkg::op_ctrl_u op_ctrl,
    input  wire [`XLEN-1:0]       operand_a,
    input  wire [`XLEN-1:0]       operand_b,
    input  wire [`TAG_W-1:0]      op_tag,
    input  wire                   grant,
    output logic                  busy,
    output logic                  done,
    output logic [`XLEN-1:0]      result,
    output logic [`TAG_W-1:0]     result_tag
);
    import exec_pkg::*;

    localparam int CNT_W = $clog2(`MULT_STEPS + 1);

    logic                   running;
    logic [CNT_W-1:0]       step_cnt;
    logic                   last_step;
    logic                   neg_a;
    logic                   neg_b;
    logic [`XLEN-1:0]       mag_a;
    logic [`XLEN-1:0]       mag_b;
    logic                   neg_q;
    logic                   high_q;
    logic [2*`XLEN-1:0]     mcand;
    logic [`XLEN-1:0]       mplier;
    logic [2*`XLEN-1:0]     product;
    logic [2*`XLEN-1:0]     partial;
    logic [2*`XLEN-1:0]     product_next;
    logic [2*`XLEN-1:0]     signed_prod;

    //////////////////////////////
    // sign handling
    //////////////////////////////
    // magnitudes plus one sign flag for the product
    assign neg_a = op_ctrl.mult.signed_a & operand_a[`XLEN-1];
    assign neg_b = op_ctrl.mult.signed_b & operand_b[`XLEN-1];
    assign mag_a = neg_a ? -operand_a : operand_a;
    assign mag_b = neg_b ? -operand_b : operand_b;

    // radix-4 partial product
    always_comb begin
        case (mplier[1:0])
            2'b00:   partial = '0;
            2'b01:   partial = mcand;
            2'b10:   partial = mcand << 1;
            default: partial = mcand + (mcand << 1);
        endcase
    end

    assign product_next = product + partial;
    assign signed_prod  = neg_q ? -product_next : product_next;
    assign last_step    = running && (step_cnt == CNT_W'(`MULT_STEPS - 1));

    // step counter and done level
    always_ff @(posedge clock) begin
        if (reset) begin
            running  <= 1'b0;
            step_cnt <= '0;
            done     <= 1'b0;
        end else begin
            if (mult_start) begin
                running  <= 1'b1;
                step_cnt <= '0;
            end else if (running) begin
                step_cnt <= step_cnt + CNT_W'(1);
                if (last_step) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
            // grant only comes while idle and done
            if (grant) begin
                done <= 1'b0;
            end
        end
    end

    //////////////////////////////
    // shift-add datapath
    //////////////////////////////
    always_ff @(posedge clock) begin
        if (mult_start) begin
            mcand      <= {{`XLEN{1'b0}}, mag_a};
            mplier     <= mag_b;
            product    <= '0;
            neg_q      <= neg_a ^ neg_b;
            high_q     <= op_ctrl.mult.high;
            result_tag <= op_tag;
        end else if (running) begin
            product <= product_next;
            mcand   <= mcand << 2;
            mplier  <= mplier >> 2;
            // sign fix and half select on the final step
            if (last_step) begin
                result <= high_q ? signed_prod[2*`XLEN-1:`XLEN] : signed_prod[`XLEN-1:0];
            end
        end
    end

    assign busy = running | done;

    a_step_bound: assert property (@(posedge clock) disable iff (reset)
        step_cnt <= CNT_W'(`MULT_STEPS));

endmodule

`default_nettype wire

//--- tb.f
+incdir+design
design/exec_pkg.sv
design/dispatch_port.sv
design/alu_unit.sv
design/mult_unit.sv
design/cdb_arbiter.sv
design/exec_core.sv
bench/clock_gen.sv
bench/exec_core_tb.sv
